/* errtrack.f */
+incdir+include
hdl/errtrack_pkg.sv
hdl/errtrack_if.sv
hdl/trigger_counter.sv
hdl/history_window.sv
hdl/errtrack_ctrl.sv
hdl/capture_memory.sv
hdl/errtrack_top.sv
verif/errtrack_assertions.sv
verif/errtrack_checker.sv
verif/errtrack_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the errtrack testbench with Verilator, runs it and greps the log for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f errtrack.f --top-module errtrack_tb \
    -o errtrack_sim > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }

./obj_dir/errtrack_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "^Verification passed$" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

/* verif/errtrack_testdata.txt */
# test_id mode cycles trigger_density_percent rearm
# one test per line, the density is the chance that any single trigger flag is set.
1 0 60 4 0
2 1 60 25 0
3 2 60 40 0
4 3 80 60 0
5 0 120 50 0
6 0 60 30 1

/* verif/errtrack_tb.sv */
`default_nettype none

`include "errtrack_settings.svh"

module errtrack_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rstb;
    logic [7:0]  prbs_flags_i;
    logic [7:0]  prbs_trigger_i;
    logic [31:0] est_error_i;
    logic [11:0] symbols_i;
    logic [11:0] sd_flags_i;
    logic [1:0]  mode_i;
    logic        arm_i;
    logic [5:0]  rd_addr_i;
    logic [63:0] rd_data_o;
    logic        rd_is_header_o;
    logic        done_o;
    logic        rd_valid;
    logic        test_done;
    int          test_id;
    int          errors;
    int          tests;
    int          bad_tests;
    int          assert_fails;
    int          cycles;
    int          limit;
    int          ids[$];
    int          modes[$];
    int          lens[$];
    int          dens[$];
    int          rearms[$];

    errtrack_top errtrack_top_inst (
        .clk            (clk),
        .rstb           (rstb),
        .prbs_flags_i   (prbs_flags_i),
        .prbs_trigger_i (prbs_trigger_i),
        .est_error_i    (est_error_i),
        .symbols_i      (symbols_i),
        .sd_flags_i     (sd_flags_i),
        .mode_i         (mode_i),
        .arm_i          (arm_i),
        .rd_addr_i      (rd_addr_i),
        .rd_data_o      (rd_data_o),
        .rd_is_header_o (rd_is_header_o),
        .done_o         (done_o)
    );

    errtrack_checker errtrack_checker_inst (
        .clk(clk), .rstb(rstb), .prbs_flags_i(prbs_flags_i), .prbs_trigger_i(prbs_trigger_i),
        .est_error_i(est_error_i), .symbols_i(symbols_i), .sd_flags_i(sd_flags_i),
        .mode_i(mode_i), .arm_i(arm_i), .rd_addr_i(rd_addr_i), .rd_valid_i(rd_valid),
        .rd_data_o(rd_data_o), .rd_is_header_o(rd_is_header_o), .done_o(done_o),
        .test_done_i(test_done), .test_id_i(test_id), .errors_o(errors), .tests_o(tests),
        .bad_tests_o(bad_tests)
    );

    bind errtrack_ctrl errtrack_assertions errtrack_assertions_inst (
        .clk(clk), .rstb(rstb), .wr_en(write_ok), .wr_addr(addr_q), .full(full_q),
        .done_o(done_o), .arm_i(arm_i), .snap_o(snap_o)
    );

    // each trigger flag is set with the given chance in percent.
    function automatic logic [7:0] draw_flags(input int density);
        logic [7:0] f;
        for (int b = 0; b < 8; b++) begin
            f[b] = (($urandom % 100) < density);
        end
        return f;
    endfunction

    task automatic load_tests();
        int    fd;
        int    n;
        int    v[5];
        string line;
        fd = $fopen("verif/errtrack_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.substr(0, 0) != "#") begin
                    if ($sscanf(line, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]) == 5) begin
                        ids.push_back(v[0]);
                        modes.push_back(v[1]);
                        lens.push_back(v[2]);
                        dens.push_back(v[3]);
                        rearms.push_back(v[4]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rstb           = 1'b0;
        prbs_flags_i   = '0;
        prbs_trigger_i = '0;
        est_error_i    = '0;
        symbols_i      = '0;
        sd_flags_i     = '0;
        mode_i         = '0;
        arm_i          = 1'b0;
        rd_addr_i      = '0;
        rd_valid       = 1'b0;
        test_done      = 1'b0;
        test_id        = 0;
        cycles         = 0;
        limit          = 0;
        assert_fails   = 0;
        void'($urandom(10237));
        load_tests();
        if (ids.size() == 0) begin
            $display("no tests could be read from verif/errtrack_testdata.txt");
            $display("Verification failed");
            $finish;
        end else begin
            limit = 100 + 70 * ids.size();
            foreach (lens[t]) begin
                limit += lens[t];
            end
            repeat (2) @(posedge clk);
            rstb <= 1'b1;
            foreach (ids[t]) begin
                @(posedge clk);
                mode_i <= modes[t][1:0];
                if (rearms[t] != 0) begin
                    arm_i <= 1'b1;
                    @(posedge clk);
                    arm_i <= 1'b0;
                end
                repeat (lens[t]) begin
                    @(posedge clk);
                    prbs_trigger_i <= draw_flags(dens[t]);
                    prbs_flags_i   <= 8'($urandom);
                    est_error_i    <= $urandom;
                    symbols_i      <= 12'($urandom);
                    sd_flags_i     <= 12'($urandom);
                end
                @(posedge clk);
                prbs_trigger_i <= '0;
                repeat (6) @(posedge clk); // lets a capture burst in flight finish.
                for (int a = 0; a < 64; a++) begin
                    @(posedge clk);
                    rd_valid  <= 1'b1;
                    rd_addr_i <= 6'(a);
                end
                @(posedge clk);
                rd_valid <= 1'b0;
                @(posedge clk);
                test_done <= 1'b1;
                test_id   <= ids[t];
                @(posedge clk);
                test_done <= 1'b0;
            end
            repeat (2) @(posedge clk);
            assert_fails =
                errtrack_top_inst.errtrack_ctrl_inst.errtrack_assertions_inst.fail_cnt;
            $display("tests %0d, failing tests %0d, mismatches %0d, assertion failures %0d",
                     tests, bad_tests, errors, assert_fails);
            if (errors == 0 && assert_fails == 0 && tests == ids.size()) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule : errtrack_tb

`default_nettype wire

/* verif/errtrack_checker.sv */
`default_nettype none

`include "errtrack_settings.svh"

module errtrack_checker (
    input  logic        clk,
    input  logic        rstb,
    input  logic [7:0]  prbs_flags_i,
    input  logic [7:0]  prbs_trigger_i,
    input  logic [31:0] est_error_i,
    input  logic [11:0] symbols_i,
    input  logic [11:0] sd_flags_i,
    input  logic [1:0]  mode_i,
    input  logic        arm_i,
    input  logic [5:0]  rd_addr_i,
    input  logic        rd_valid_i,   // rd_addr_i holds an address to be checked.
    input  logic [63:0] rd_data_o,
    input  logic        rd_is_header_o,
    input  logic        done_o,
    input  logic        test_done_i,
    input  int          test_id_i,
    output int          errors_o,
    output int          tests_o,
    output int          bad_tests_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [64:0] exp_mem [64];   // bit 64 marks a header.
    logic        written [64];
    logic [63:0] hist [3];       // hist[2] is the newest sample.
    logic [5:0]  addr;
    logic [7:0]  idx;
    logic        full;
    int          edge_idx;
    int          block_until;
    int          pend_cnt;
    int          cnt_now;
    int          caps;
    int          test_errs;
    logic        cmp_pending;
    logic [5:0]  cmp_addr;

    function automatic logic [63:0] lane_word(input logic [31:0] err, input logic [11:0] sym,
                                              input logic [11:0] sd, input logic [7:0] prbs);
        logic [63:0] w;
        for (int l = 0; l < 4; l++) begin
            w[l*16 +: 16] = {err[l*8 +: 8], sym[l*3 +: 3], sd[l*3 +: 3], prbs[l*2 +: 2]};
        end
        return w;
    endfunction

    task automatic store(input logic [64:0] entry);
        exp_mem[addr] = entry;
        written[addr] = 1'b1;
        if (addr == 6'd63) begin
            full = 1'b1; // the sixteenth capture fills the memory.
        end
        addr = addr + 6'd1;
    endtask

    initial begin
        errors_o    = 0;
        tests_o     = 0;
        bad_tests_o = 0;
        test_errs   = 0;
        caps        = 0;
        cmp_pending = 1'b0;
        cmp_addr    = '0;
        for (int a = 0; a < 64; a++) begin
            written[a] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rstb) begin
            edge_idx    = 0;
            block_until = -10;
            pend_cnt    = 0;
            addr        = '0;
            idx         = '0;
            full        = 1'b0;
            hist[0]     = '0;
            hist[1]     = '0;
            hist[2]     = '0;
        end else begin
            cnt_now = $countones(prbs_trigger_i);
            if (arm_i) begin
                addr = '0;
                idx  = '0;
                full = 1'b0;
            end else if (pend_cnt > int'(mode_i) && edge_idx > block_until && !full) begin
                // the trigger belongs to the previous edge, which is also the stamp.
                store({1'b1, 32'(edge_idx - 1), idx, 8'(pend_cnt), 16'h0});
                store({1'b0, hist[0]});
                store({1'b0, hist[1]});
                store({1'b0, hist[2]});
                idx         = idx + 8'd1;
                block_until = edge_idx + 4;
                caps++;
            end
            hist[0]  = hist[1];
            hist[1]  = hist[2];
            hist[2]  = lane_word(est_error_i, symbols_i, sd_flags_i, prbs_flags_i);
            pend_cnt = cnt_now;
            edge_idx++;
        end

        if (cmp_pending && written[cmp_addr]) begin
            if (rd_data_o !== exp_mem[cmp_addr][63:0]) begin
                $display("[ERROR] %0t rd_data_o addr %0d expected %h actual %h",
                         $time, cmp_addr, exp_mem[cmp_addr][63:0], rd_data_o);
                test_errs++;
            end
            if (rd_is_header_o !== exp_mem[cmp_addr][64]) begin
                $display("[ERROR] %0t rd_is_header_o addr %0d expected %b actual %b",
                         $time, cmp_addr, exp_mem[cmp_addr][64], rd_is_header_o);
                test_errs++;
            end
        end
        if (cmp_pending && done_o !== full) begin
            $display("[ERROR] %0t done_o expected %b actual %b", $time, full, done_o);
            test_errs++;
        end
        cmp_pending = rd_valid_i;
        cmp_addr    = rd_addr_i;

        if (test_done_i) begin
            $display("test %0d mode %0d: %0d captures, %0d mismatches, %s",
                     test_id_i, mode_i, caps, test_errs, (test_errs == 0) ? "ok" : "MISMATCH");
            errors_o += test_errs;
            tests_o++;
            if (test_errs != 0) begin
                bad_tests_o++;
            end
            test_errs = 0;
            caps      = 0;
        end
    end

endmodule : errtrack_checker

`default_nettype wire

/* verif/errtrack_assertions.sv */
`default_nettype none

`include "errtrack_settings.svh"

module errtrack_assertions (
    input logic                    clk,
    input logic                    rstb,
    input logic                    wr_en,
    input logic [`ERRT_ADDR_W-1:0] wr_addr,
    input logic                    full,
    input logic                    done_o,
    input logic                    arm_i,
    input logic                    snap_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // number of assertion failures so far.

    // header plus three window entries, then the write enable drops.
    a_burst_len : assert property (@(posedge clk) disable iff (!rstb)
        snap_o |=> wr_en ##1 wr_en ##1 wr_en ##1 wr_en ##1 !wr_en)
        else begin
            fail_cnt++;
            $error("write burst is not four cycles long");
        end

    a_done_hold : assert property (@(posedge clk) disable iff (!rstb)
        $fell(done_o) |-> $past(arm_i))
        else begin
            fail_cnt++;
            $error("done_o fell without an arm pulse");
        end

    a_full_stop : assert property (@(posedge clk) disable iff (!rstb)
        (full && !arm_i) |=> $stable(wr_addr))
        else begin
            fail_cnt++;
            $error("write address moved while the memory was full");
        end

endmodule : errtrack_assertions

`default_nettype wire

/* hdl/errtrack_top.sv */
`default_nettype none

`include "errtrack_settings.svh"

module errtrack_top import errtrack_pkg::*; (
    input  logic                                clk,
    input  logic                                rstb,
    input  logic [`ERRT_TRIG_W-1:0]             prbs_flags_i,
    input  logic [`ERRT_TRIG_W-1:0]             prbs_trigger_i,
    input  logic [`ERRT_LANES*`ERRT_ERR_W-1:0]  est_error_i,
    input  logic [`ERRT_LANES*`ERRT_SYM_W-1:0]  symbols_i,
    input  logic [`ERRT_LANES*`ERRT_FLAG_W-1:0] sd_flags_i,
    input  logic [1:0]                          mode_i,
    input  logic                                arm_i,
    input  logic [`ERRT_ADDR_W-1:0]             rd_addr_i,
    output logic [`ERRT_DATA_W-1:0]             rd_data_o,
    output logic                                rd_is_header_o,
    output logic                                done_o
);

    lane_set_t              lanes;
    window_t                snapshot;
    logic                   trig;
    logic                   snap;
    logic [`ERRT_CNT_W-1:0] ones;
    entry_t                 rd_entry;

    capture_wr_if capture_wr_if_inst ();

    // lane l takes its slice of every flat input bus.
    always_comb begin
        for (int l = 0; l < `ERRT_LANES; l++) begin
            lanes[l].est_error  = est_error_i[l*`ERRT_ERR_W +: `ERRT_ERR_W];
            lanes[l].symbol     = symbols_i[l*`ERRT_SYM_W +: `ERRT_SYM_W];
            lanes[l].sd_flags   = sd_flags_i[l*`ERRT_FLAG_W +: `ERRT_FLAG_W];
            lanes[l].prbs_flags = prbs_flags_i[l*`ERRT_PRBS_W +: `ERRT_PRBS_W];
        end
    end

    trigger_counter trigger_counter_inst (
        .clk            (clk),
        .rstb           (rstb),
        .prbs_trigger_i (prbs_trigger_i),
        .mode_i         (mode_i),
        .trig_o         (trig),
        .ones_o         (ones)
    );

    history_window history_window_inst (
        .clk        (clk),
        .rstb       (rstb),
        .lanes_i    (lanes),
        .snap_i     (snap),
        .snapshot_o (snapshot)
    );

    errtrack_ctrl errtrack_ctrl_inst (
        .clk        (clk),
        .rstb       (rstb),
        .trig_i     (trig),
        .ones_i     (ones),
        .arm_i      (arm_i),
        .snapshot_i (snapshot),
        .snap_o     (snap),
        .done_o     (done_o),
        .wr         (capture_wr_if_inst.ctrl)
    );

    capture_memory capture_memory_inst (
        .clk        (clk),
        .wr         (capture_wr_if_inst.mem),
        .rd_addr_i  (rd_addr_i),
        .rd_entry_o (rd_entry)
    );

    assign rd_data_o      = rd_entry.data;
    assign rd_is_header_o = rd_entry.is_header;

endmodule : errtrack_top

`default_nettype wire

/* hdl/capture_memory.sv */
`default_nettype none

`include "errtrack_settings.svh"

module capture_memory import errtrack_pkg::*; (
    input  logic                    clk,
    capture_wr_if.mem               wr,
    input  logic [`ERRT_ADDR_W-1:0] rd_addr_i,
    output entry_t                  rd_entry_o
);

    localparam int DEPTH = 2 ** `ERRT_ADDR_W;

    entry_t mem [DEPTH];
    entry_t rd_entry_q;

    // the control block already stops writing once full is set.
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        rd_entry_q <= mem[rd_addr_i]; // one cycle from address to data.
    end

    assign rd_entry_o = rd_entry_q;

endmodule : capture_memory

`default_nettype wire

/* hdl/errtrack_ctrl.sv */
`default_nettype none

`include "errtrack_settings.svh"

module errtrack_ctrl import errtrack_pkg::*; (
    input  logic                   clk,
    input  logic                   rstb,
    input  logic                   trig_i,
    input  logic [`ERRT_CNT_W-1:0] ones_i,
    input  logic                   arm_i,
    input  window_t                snapshot_i,
    output logic                   snap_o,
    output logic                   done_o,
    capture_wr_if.ctrl             wr
);

    localparam int PH_W = $clog2(`ERRT_WINDOW + 1);
    localparam logic [PH_W-1:0] LAST_PH = PH_W'(`ERRT_WINDOW);

    logic                     busy_q;
    logic [PH_W-1:0]          phase_q;   // 0 is the header, then one per window cycle.
    logic                     full_q;
    logic [`ERRT_ADDR_W-1:0]  addr_q;
    logic [`ERRT_IDX_W-1:0]   cap_idx_q;
    logic [`ERRT_STAMP_W-1:0] stamp_cnt_q;
    logic [`ERRT_STAMP_W-1:0] hdr_stamp_q;
    logic [`ERRT_IDX_W-1:0]   hdr_idx_q;
    logic [`ERRT_CNT_W-1:0]   hdr_ones_q;
    logic                     start;
    logic                     write_ok;
    logic                     last_wr;

    // an arm pulse wins over a trigger in the same cycle.
    assign start    = trig_i && !busy_q && !full_q && !arm_i;
    assign write_ok = busy_q && !full_q;
    assign last_wr  = (phase_q == LAST_PH);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            stamp_cnt_q <= '1; // reads 0 after the first edge out of reset.
            busy_q      <= 1'b0;
            phase_q     <= '0;
            full_q      <= 1'b0;
            addr_q      <= '0;
            cap_idx_q   <= '0;
        end else begin
            stamp_cnt_q <= stamp_cnt_q + 1'b1;
            if (start) begin
                busy_q    <= 1'b1;
                phase_q   <= '0;
                cap_idx_q <= cap_idx_q + 1'b1;
            end else if (busy_q) begin
                phase_q <= phase_q + 1'b1;
                if (last_wr) begin
                    busy_q <= 1'b0;
                end
            end
            if (write_ok) begin
                addr_q <= addr_q + 1'b1;
                if (addr_q == '1) begin
                    full_q <= 1'b1; // last slot taken, the address wrapped.
                end
            end
            if (arm_i) begin
                addr_q    <= '0;
                full_q    <= 1'b0;
                cap_idx_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_stamp_q <= stamp_cnt_q; // equals the edge that fired the trigger.
            hdr_idx_q   <= cap_idx_q;
            hdr_ones_q  <= ones_i;
        end
    end

    always_comb begin
        wr.wr_entry = '0;
        if (phase_q == '0) begin
            wr.wr_entry.is_header        = 1'b1;
            wr.wr_entry.data.hdr.stamp   = hdr_stamp_q;
            wr.wr_entry.data.hdr.cap_idx = hdr_idx_q;
            wr.wr_entry.data.hdr.ones    = hdr_ones_q;
        end else begin
            wr.wr_entry.data.lanes = snapshot_i[phase_q - 1'b1];
        end
    end

    assign wr.wr_en   = write_ok;
    assign wr.wr_addr = addr_q;
    assign wr.full    = full_q;
    assign snap_o     = start;
    assign done_o     = full_q;

endmodule : errtrack_ctrl

`default_nettype wire

/* hdl/history_window.sv */
`default_nettype none

`include "errtrack_settings.svh"

module history_window import errtrack_pkg::*; (
    input  logic      clk,
    input  logic      rstb,
    input  lane_set_t lanes_i,
    input  logic      snap_i,
    output window_t   snapshot_o
);

    window_t taps_q;     // taps_q[WINDOW-1] holds the newest cycle.
    window_t snapshot_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            taps_q <= '0;
        end else begin
            for (int i = 0; i < `ERRT_WINDOW - 1; i++) begin
                taps_q[i] <= taps_q[i+1];
            end
            taps_q[`ERRT_WINDOW-1] <= lanes_i;
        end
    end

    // the snapshot holds still through the write burst while the taps keep moving.
    always_ff @(posedge clk) begin
        if (snap_i) begin
            snapshot_q <= taps_q;
        end
    end

    assign snapshot_o = snapshot_q;

endmodule : history_window

`default_nettype wire

/* hdl/trigger_counter.sv */
`default_nettype none

`include "errtrack_settings.svh"

module trigger_counter (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic [`ERRT_TRIG_W-1:0] prbs_trigger_i,
    input  logic [1:0]              mode_i,
    output logic                    trig_o,
    output logic [`ERRT_CNT_W-1:0]  ones_o
);

    localparam int CNT_W = `ERRT_CNT_W;

    logic [`ERRT_TRIG_W-1:0] trig_flags_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trig_flags_q <= '0;
        end else begin
            trig_flags_q <= prbs_trigger_i;
        end
    end

    always_comb begin
        ones_o = '0;
        for (int i = 0; i < `ERRT_TRIG_W; i++) begin
            ones_o = ones_o + CNT_W'(trig_flags_q[i]);
        end
    end

    // mode 0..3 needs 1..4 flags in the same cycle.
    assign trig_o = (ones_o > CNT_W'(mode_i));

endmodule : trigger_counter

`default_nettype wire

/* hdl/errtrack_if.sv */
`default_nettype none

`include "errtrack_settings.svh"

interface capture_wr_if import errtrack_pkg::*; ();

    logic                    wr_en;
    logic [`ERRT_ADDR_W-1:0] wr_addr;
    entry_t                  wr_entry;
    logic                    full;   // memory has taken its last entry until re-armed.

    modport ctrl (
        output wr_en,
        output wr_addr,
        output wr_entry,
        output full
    );

    // full is here so the stop is visible at the memory side, it gates nothing there.
    modport mem (
        input wr_en,
        input wr_addr,
        input wr_entry,
        input full
    );

endinterface : capture_wr_if

`default_nettype wire

/* hdl/errtrack_pkg.sv */
`default_nettype none

`include "errtrack_settings.svh"

package errtrack_pkg;

    typedef struct packed {
        logic signed [`ERRT_ERR_W-1:0]  est_error;
        logic signed [`ERRT_SYM_W-1:0]  symbol;
        logic        [`ERRT_FLAG_W-1:0] sd_flags;
        logic        [`ERRT_PRBS_W-1:0] prbs_flags;
    } lane_rec_t;

    typedef lane_rec_t [`ERRT_LANES-1:0] lane_set_t; // one cycle of all lanes.

    // index 0 is the oldest cycle of the window.
    typedef lane_set_t [`ERRT_WINDOW-1:0] window_t;

    typedef struct packed {
        logic [`ERRT_STAMP_W-1:0] stamp;
        logic [`ERRT_IDX_W-1:0]   cap_idx;
        logic [`ERRT_CNT_W-1:0]   ones;
        logic [`ERRT_PAD_W-1:0]   pad;
    } hdr_rec_t;

    // a memory word is read either as a header or as one cycle of lanes.
    typedef union packed {
        lane_set_t lanes;
        hdr_rec_t  hdr;
    } entry_u;

    typedef struct packed {
        logic   is_header;
        entry_u data;
    } entry_t;

endpackage : errtrack_pkg

`default_nettype wire

/* include/errtrack_settings.svh */
`ifndef ERRTRACK_SETTINGS_SVH
`define ERRTRACK_SETTINGS_SVH

// lane geometry of the equalizer output.
`define ERRT_LANES   4
`define ERRT_ERR_W   8
`define ERRT_SYM_W   3
`define ERRT_FLAG_W  3
`define ERRT_PRBS_W  2

`define ERRT_LANE_W  (`ERRT_ERR_W + `ERRT_SYM_W + `ERRT_FLAG_W + `ERRT_PRBS_W)
`define ERRT_DATA_W  (`ERRT_LANES * `ERRT_LANE_W)
`define ERRT_TRIG_W  (`ERRT_LANES * `ERRT_PRBS_W)

// capture geometry.
`define ERRT_WINDOW  3
`define ERRT_ADDR_W  6

// header fields, the pad fills the word up to the lane data width.
`define ERRT_STAMP_W 32
`define ERRT_IDX_W   8
`define ERRT_CNT_W   8
`define ERRT_PAD_W   (`ERRT_DATA_W - `ERRT_STAMP_W - `ERRT_IDX_W - `ERRT_CNT_W)

`endif
